/* include/acc_defines.svh */
// ----------------------------------------------------------
// shared macros for the accumulator pipeline
// include where a pointer or counter width is derived
// ----------------------------------------------------------
`ifndef ACC_DEFINES_SVH
`define ACC_DEFINES_SVH

// ceiling log2 that never returns 0
// a one-entry structure still needs a one-bit pointer
`define SAFE_CLOG2(x) (((x) <= 1) ? 1 : $clog2(x))

`endif

/* logic/acc_pkg.sv */
// ----------------------------------------------------------
// common types for the accumulator command pipeline
// referenced by scoped name from ingress, fifo, engine, top
// ----------------------------------------------------------
package acc_pkg;

   // accumulator width, wraps on overflow
   localparam int ACC_W = 16;

   // operand width carried in each command
   localparam int OPND_W = 8;

   // width of the emit sequence count
   localparam int SEQ_W = 8;

   // command opcodes
   // encodings 5 to 7 are illegal and dropped at ingress
   typedef enum logic [2:0]
   {
      ACC_LOAD = 3'd0,
      ACC_ADD  = 3'd1,
      ACC_SUB  = 3'd2,
      ACC_MUL  = 3'd3,
      ACC_EMIT = 3'd4
   } acc_op_e;

   // one command as it travels through ingress and fifo
   typedef struct packed
   {
      acc_op_e           op;
      logic [OPND_W-1:0] opnd;
   } acc_cmd_s;

   // result presented on each emit
   // seq counts emits from 0 and wraps
   typedef struct packed
   {
      logic [ACC_W-1:0] acc;
      logic [SEQ_W-1:0] seq;
   } acc_res_s;

endpackage

/* logic/cmd_ingress.sv */
// ----------------------------------------------------------
// command ingress stage
// accepts valid-ready commands, drops illegal opcodes with a
// one-cycle error pulse, holds legal ones for the fifo
// ----------------------------------------------------------
`timescale 1ns/1ps

module cmd_ingress
(
   input  logic              clk_i,
   input  logic              reset_i,

   input  acc_pkg::acc_cmd_s cmd_i,
   input  logic              cmd_v_i,
   output logic              cmd_ready_o,

   output logic              err_o,

   output acc_pkg::acc_cmd_s ent_o,
   output logic              ent_v_o,
   input  logic              ent_ready_i
);

   // single holding stage
   acc_pkg::acc_cmd_s ent_r;
   logic              ent_v_r;

   // held low through reset, set on the first cycle after it
   logic              run_r;
   logic              err_r;

   logic              accept;
   logic              legal;

   // anything above emit is an unknown opcode
   assign legal = (cmd_i.op <= acc_pkg::ACC_EMIT);

   // room when the stage is empty or drains this cycle
   assign cmd_ready_o = run_r & (~ent_v_r | ent_ready_i);
   assign accept      = cmd_v_i & cmd_ready_o;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         run_r   <= 1'b0;
         ent_v_r <= 1'b0;
         err_r   <= 1'b0;
      end
      else
      begin
         run_r   <= 1'b1;
         // new legal command refills, otherwise a take empties the stage
         ent_v_r <= (accept & legal) | (ent_v_r & ~ent_ready_i);
         err_r   <= accept & ~legal;
      end
   end

   // payload only, qualified by ent_v_r
   always_ff @(posedge clk_i)
   begin
      if (accept & legal)
      begin
         ent_r <= cmd_i;
      end
   end

   assign ent_o   = ent_r;
   assign ent_v_o = ent_v_r;
   assign err_o   = err_r;

   // a stalled entry must not change or vanish before the fifo takes it
   a_ent_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      (ent_v_o & ~ent_ready_i) |=> (ent_v_o && $stable(ent_o)));

endmodule

/* logic/cmd_fifo.sv */
// ----------------------------------------------------------
// small fifo on a register file
// valid-ready on the write side, valid-yumi on the read side
// depth set by els_p, any value of 2 or more
// ----------------------------------------------------------
`timescale 1ns/1ps

`include "acc_defines.svh"

module cmd_fifo
#(
   parameter int width_p = 8,
   parameter int els_p   = 4
)
(
   input  logic               clk_i,
   input  logic               reset_i,

   input  logic [width_p-1:0] data_i,
   input  logic               v_i,
   output logic               ready_o,

   output logic               v_o,
   output logic [width_p-1:0] data_o,
   input  logic               yumi_i
);

   localparam int ptr_w_lp = `SAFE_CLOG2(els_p);
   localparam logic [ptr_w_lp-1:0] last_lp = ptr_w_lp'(els_p - 1);

   // entry storage, no reset
   logic [width_p-1:0] storage [els_p];

   logic [ptr_w_lp-1:0] rptr_r;
   logic [ptr_w_lp-1:0] wptr_r;

   // last pointer-moving operation was an enqueue
   // tells full from empty when the pointers meet
   logic last_enq_r;

   logic enque;
   logic equal_ptrs;
   logic empty;
   logic full;

   // valid-ready: only counts when we are ready
   assign enque = v_i & ready_o;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rptr_r     <= '0;
         wptr_r     <= '0;
         // reset acts as a dequeue so equal pointers read as empty
         last_enq_r <= 1'b0;
      end
      else
      begin
         if (enque)
         begin
            wptr_r <= (wptr_r == last_lp) ? '0 : wptr_r + 1'b1;
         end
         if (yumi_i)
         begin
            rptr_r <= (rptr_r == last_lp) ? '0 : rptr_r + 1'b1;
         end
         // simultaneous enq and deq keep the distance, flag irrelevant
         if (enque | yumi_i)
         begin
            last_enq_r <= enque;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (enque)
      begin
         storage[wptr_r] <= data_i;
      end
   end

   assign equal_ptrs = (rptr_r == wptr_r);
   assign empty      = equal_ptrs & ~last_enq_r;
   assign full       = equal_ptrs & last_enq_r;

   // empty is already set in reset, ready needs the explicit gate
   assign ready_o = ~full & ~reset_i;
   assign v_o     = ~empty;
   assign data_o  = storage[rptr_r];

   // consumer may only take what is shown
   a_no_deq_empty: assert property (@(posedge clk_i) disable iff (reset_i)
      yumi_i |-> v_o);

   // full and undrained: nothing may overwrite the head entry
   a_no_enq_full: assert property (@(posedge clk_i) disable iff (reset_i)
      (full & ~yumi_i) |=> (full && $stable(data_o)));

endmodule

/* logic/acc_engine.sv */
// ----------------------------------------------------------
// accumulator engine, consumer side of the fifo
// takes one command per idle cycle, multiply runs 8 cycles
// emit strobes the accumulator and emit count for one cycle
// ----------------------------------------------------------
`timescale 1ns/1ps

module acc_engine
(
   input  logic              clk_i,
   input  logic              reset_i,

   input  acc_pkg::acc_cmd_s cmd_i,
   input  logic              cmd_v_i,
   output logic              yumi_o,

   output acc_pkg::acc_res_s res_o,
   output logic              res_v_o
);

   localparam int step_w_lp = $clog2(acc_pkg::OPND_W);
   localparam logic [step_w_lp-1:0] step_last_lp = step_w_lp'(acc_pkg::OPND_W - 1);

   typedef enum logic [0:0]
   {
      ST_IDLE = 1'b0,
      ST_MUL  = 1'b1
   } state_e;

   state_e state_r;

   logic [acc_pkg::ACC_W-1:0]  acc_r;
   logic [acc_pkg::SEQ_W-1:0]  emit_cnt_r;
   logic [step_w_lp-1:0]       step_r;

   // shift-and-add operands, loaded on a multiply take
   logic [acc_pkg::ACC_W-1:0]  mcand_r;
   logic [acc_pkg::OPND_W-1:0] mplier_r;

   acc_pkg::acc_res_s          res_r;
   logic                       res_v_r;

   // take whenever idle and the fifo shows an entry
   assign yumi_o = (state_r == ST_IDLE) & cmd_v_i;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r    <= ST_IDLE;
         acc_r      <= '0;
         emit_cnt_r <= '0;
         step_r     <= '0;
         res_v_r    <= 1'b0;
      end
      else
      begin
         res_v_r <= 1'b0;
         case (state_r)
            ST_IDLE:
            begin
               if (yumi_o)
               begin
                  case (cmd_i.op)
                     acc_pkg::ACC_LOAD: acc_r <= acc_pkg::ACC_W'(cmd_i.opnd);
                     acc_pkg::ACC_ADD:  acc_r <= acc_r + acc_pkg::ACC_W'(cmd_i.opnd);
                     acc_pkg::ACC_SUB:  acc_r <= acc_r - acc_pkg::ACC_W'(cmd_i.opnd);
                     acc_pkg::ACC_MUL:
                     begin
                        // acc_r becomes the partial product
                        acc_r   <= '0;
                        step_r  <= '0;
                        state_r <= ST_MUL;
                     end
                     acc_pkg::ACC_EMIT:
                     begin
                        res_v_r    <= 1'b1;
                        emit_cnt_r <= emit_cnt_r + 1'b1;
                     end
                     default:
                     begin
                        // illegal opcodes are filtered at ingress
                        acc_r <= acc_r;
                     end
                  endcase
               end
            end
            ST_MUL:
            begin
               // one multiplier bit per cycle, low 16 bits kept
               if (mplier_r[0])
               begin
                  acc_r <= acc_r + mcand_r;
               end
               step_r <= step_r + 1'b1;
               if (step_r == step_last_lp)
               begin
                  state_r <= ST_IDLE;
               end
            end
            default: state_r <= ST_IDLE;
         endcase
      end
   end

   // datapath registers without reset
   always_ff @(posedge clk_i)
   begin
      if (yumi_o & (cmd_i.op == acc_pkg::ACC_MUL))
      begin
         mcand_r  <= acc_r;
         mplier_r <= cmd_i.opnd;
      end
      else if (state_r == ST_MUL)
      begin
         mcand_r  <= mcand_r << 1;
         mplier_r <= mplier_r >> 1;
      end
      if (yumi_o & (cmd_i.op == acc_pkg::ACC_EMIT))
      begin
         res_r.acc <= acc_r;
         res_r.seq <= emit_cnt_r;
      end
   end

   assign res_o   = res_r;
   assign res_v_o = res_v_r;

   // a multiply blocks further takes for its full 8 steps
   a_mul_stall: assert property (@(posedge clk_i) disable iff (reset_i)
      (yumi_o && cmd_i.op == acc_pkg::ACC_MUL) |=> !yumi_o [*8]);

endmodule

/* logic/acc_top.sv */
// ----------------------------------------------------------
// top of the accumulator pipeline
// ingress feeds the command fifo, the engine drains it
// depth_p sets the fifo depth
// ----------------------------------------------------------
`timescale 1ns/1ps

module acc_top
#(
   parameter int depth_p = 4
)
(
   input  logic              clk_i,
   input  logic              reset_i,

   input  acc_pkg::acc_cmd_s cmd_i,
   input  logic              cmd_v_i,
   output logic              cmd_ready_o,
   output logic              err_o,

   output acc_pkg::acc_res_s res_o,
   output logic              res_v_o
);

   // fifo entry is exactly one command
   localparam int width_lp = $bits(acc_pkg::acc_cmd_s);

   // ingress to fifo
   acc_pkg::acc_cmd_s ent;
   logic              ent_v;
   logic              ent_ready;

   // fifo to engine
   acc_pkg::acc_cmd_s fifo_data;
   logic              fifo_v;
   logic              fifo_yumi;

   cmd_ingress ingress0
   (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .cmd_i       (cmd_i),
      .cmd_v_i     (cmd_v_i),
      .cmd_ready_o (cmd_ready_o),
      .err_o       (err_o),
      .ent_o       (ent),
      .ent_v_o     (ent_v),
      .ent_ready_i (ent_ready)
   );

   cmd_fifo #(.width_p(width_lp), .els_p(depth_p)) fifo0
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .data_i  (ent),
      .v_i     (ent_v),
      .ready_o (ent_ready),
      .v_o     (fifo_v),
      .data_o  (fifo_data),
      .yumi_i  (fifo_yumi)
   );

   acc_engine engine0
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .cmd_i   (fifo_data),
      .cmd_v_i (fifo_v),
      .yumi_o  (fifo_yumi),
      .res_o   (res_o),
      .res_v_o (res_v_o)
   );

endmodule

/* sim/tb_clock.sv */
// ----------------------------------------------------------
// clock and reset source for the testbench
// reset is high from time 0 for reset_cycles_p rising edges
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_clock
#(
   parameter int period_p       = 20,
   parameter int reset_cycles_p = 2
)
(
   output logic clk_o,
   output logic reset_o
);

   initial
   begin
      clk_o = 1'b0;
      forever
      begin
         #(period_p / 2) clk_o = ~clk_o;
      end
   end

   // release on a rising edge, like any other synchronous input
   initial
   begin
      reset_o = 1'b1;
      repeat (reset_cycles_p) @(posedge clk_o);
      reset_o <= 1'b0;
   end

endmodule

/* sim/acc_tb.sv */
// ----------------------------------------------------------
// testbench for the accumulator pipeline
// random commands go in, a model of the accumulator predicts
// every emit result and every error pulse
// ----------------------------------------------------------
`timescale 1ns/1ps

module acc_tb;

   localparam int depth_lp      = 4;
   localparam int accept_max_lp = 500;
   localparam int drain_max_lp  = 4000;
   localparam int idle_max_lp   = 16;

   // command mixes for rand_cmd
   localparam int mix_basic_lp   = 0;
   localparam int mix_illegal_lp = 1;

   logic              clk;
   logic              reset;
   acc_pkg::acc_cmd_s cmd;
   logic              cmd_v;
   logic              cmd_ready;
   logic              err;
   acc_pkg::acc_res_s res;
   logic              res_v;

   // reference model state
   logic [acc_pkg::ACC_W-1:0] model_acc  = '0;
   logic [acc_pkg::SEQ_W-1:0] model_seq  = '0;
   acc_pkg::acc_res_s         exp_q [$];
   acc_pkg::acc_res_s         exp_res;
   int                        err_exp    = 0;
   int                        err_seen   = 0;
   // set at the falling edge when the next rising edge accepts cmd
   logic                      fire       = 1'b0;
   logic                      stall_seen = 1'b0;
   int                        i;

   tb_clock #(.period_p(20), .reset_cycles_p(2)) clock0
   (
      .clk_o   (clk),
      .reset_o (reset)
   );

   acc_top #(.depth_p(depth_lp)) dut0
   (
      .clk_i       (clk),
      .reset_i     (reset),
      .cmd_i       (cmd),
      .cmd_v_i     (cmd_v),
      .cmd_ready_o (cmd_ready),
      .err_o       (err),
      .res_o       (res),
      .res_v_o     (res_v)
   );

   task automatic stop_on_error();
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic report_failure(input string what);
      $display("%s at %0t ns", what, $time);
      stop_on_error();
   endtask

   task automatic check_res(input acc_pkg::acc_res_s got, input acc_pkg::acc_res_s exp);
      if (got !== exp)
      begin
         $display("error at %0t ns: res_o expected acc %h seq %0d, got acc %h seq %0d",
                  $time, exp.acc, exp.seq, got.acc, got.seq);
         stop_on_error();
      end
   endtask

   task automatic check_err(input int got, input int exp);
      if (got != exp)
      begin
         $display("error at %0t ns: err_o pulses expected %0d, got %0d", $time, exp, got);
         stop_on_error();
      end
   endtask

   task automatic check_ready(input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("error at %0t ns: cmd_ready_o expected %b, got %b", $time, exp, got);
         stop_on_error();
      end
   endtask

   // model update, in acceptance order, which is also execution order
   task automatic apply_model(input acc_pkg::acc_cmd_s c);
      acc_pkg::acc_res_s r;
      case (c.op)
         acc_pkg::ACC_LOAD: model_acc = acc_pkg::ACC_W'(c.opnd);
         acc_pkg::ACC_ADD:  model_acc = model_acc + acc_pkg::ACC_W'(c.opnd);
         acc_pkg::ACC_SUB:  model_acc = model_acc - acc_pkg::ACC_W'(c.opnd);
         // product truncated to the accumulator width
         acc_pkg::ACC_MUL:  model_acc = model_acc * acc_pkg::ACC_W'(c.opnd);
         acc_pkg::ACC_EMIT:
         begin
            r.acc = model_acc;
            r.seq = model_seq;
            exp_q.push_back(r);
            model_seq = model_seq + 1'b1;
         end
         default: err_exp++;
      endcase
   endtask

   function automatic acc_pkg::acc_cmd_s make_cmd(input acc_pkg::acc_op_e op,
                                                  input logic [7:0] opnd);
      acc_pkg::acc_cmd_s c;
      c.op   = op;
      c.opnd = opnd;
      return c;
   endfunction

   // emits about 15 percent, multiply and illegal only in the wide mix
   function automatic acc_pkg::acc_cmd_s rand_cmd(input int mix);
      acc_pkg::acc_cmd_s c;
      int unsigned       pick;
      pick   = $urandom_range(99);
      c.opnd = 8'($urandom);
      if (mix == mix_illegal_lp && pick < 10)
         c.op = acc_pkg::acc_op_e'(3'($urandom_range(7, 5)));
      else if (pick < 25)
         c.op = acc_pkg::ACC_EMIT;
      else if (mix == mix_illegal_lp && pick < 35)
         c.op = acc_pkg::ACC_MUL;
      else
         c.op = acc_pkg::acc_op_e'(3'($urandom_range(2, 0)));
      return c;
   endfunction

   // optional idle cycles, then hold the command until it is taken
   task automatic send_cmd(input acc_pkg::acc_cmd_s c, input int gap_pct);
      int waited;
      int idle;
      waited = 0;
      idle   = 0;
      while (idle < idle_max_lp && $urandom_range(99) < gap_pct)
      begin
         cmd_v <= 1'b0;
         idle++;
         @(posedge clk);
      end
      cmd   <= c;
      cmd_v <= 1'b1;
      @(posedge clk);
      while (!fire)
      begin
         if (waited >= accept_max_lp)
            report_failure("command was never accepted");
         waited++;
         @(posedge clk);
      end
   endtask

   // ready low through reset and the first cycle after, then high
   // flops are unknown until the first reset edge, so checks start after it
   task automatic wait_reset_release();
      int waited;
      waited = 0;
      @(posedge clk);
      @(negedge clk);
      while (reset)
      begin
         check_ready(cmd_ready, 1'b0);
         if (waited >= 10)
            report_failure("reset was never released");
         waited++;
         @(negedge clk);
      end
      check_ready(cmd_ready, 1'b0);
      @(negedge clk);
      check_ready(cmd_ready, 1'b1);
      @(posedge clk);
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 || err_seen != err_exp)
      begin
         if (waited >= drain_max_lp)
            report_failure("results still outstanding after the last command");
         waited++;
         @(posedge clk);
      end
   endtask

   // outputs are sampled mid-cycle where they are stable
   always @(negedge clk)
   begin
      fire = 1'b0;
      if (err)
         err_seen++;
      check_err(err_seen, err_exp);
      if (res_v)
      begin
         if (exp_q.size() == 0)
            report_failure("res_v_o strobed with no emit outstanding");
         exp_res = exp_q.pop_front();
         check_res(res, exp_res);
      end
      if (cmd_v && !cmd_ready)
         stall_seen = 1'b1;
      if (cmd_v && cmd_ready)
      begin
         fire = 1'b1;
         apply_model(cmd);
      end
   end

   initial
   begin
      cmd   = '0;
      cmd_v = 1'b0;
      void'($urandom(32'h12f1_2353));
      wait_reset_release();

      // load, add and sub with emits, wrap checked through the model
      for (i = 0; i < 300; i++)
      begin
         send_cmd(rand_cmd(mix_basic_lp), 10);
      end
      send_cmd(make_cmd(acc_pkg::ACC_EMIT, 8'h00), 0);

      // back-to-back multiplies stall the engine and fill the fifo
      stall_seen = 1'b0;
      for (i = 0; i < 8; i++)
      begin
         send_cmd(make_cmd(acc_pkg::ACC_LOAD, 8'($urandom)), 0);
         send_cmd(make_cmd(acc_pkg::ACC_MUL, 8'($urandom)), 0);
         send_cmd(make_cmd(acc_pkg::ACC_MUL, 8'($urandom)), 0);
         send_cmd(make_cmd(acc_pkg::ACC_EMIT, 8'h00), 0);
      end
      if (!stall_seen)
         report_failure("cmd_ready_o never fell during the multiply burst");

      // illegal opcodes mixed in
      for (i = 0; i < 300; i++)
      begin
         send_cmd(rand_cmd(mix_illegal_lp), 20);
      end

      // long run with random gaps on cmd_v
      for (i = 0; i < 2000; i++)
      begin
         send_cmd(rand_cmd(mix_illegal_lp), 30);
      end
      send_cmd(make_cmd(acc_pkg::ACC_EMIT, 8'h00), 0);
      cmd_v <= 1'b0;

      wait_drain();
      $display("Test OK");
      $finish;
   end

endmodule

/* sources.f */
+incdir+include
logic/acc_pkg.sv
logic/cmd_ingress.sv
logic/cmd_fifo.sv
logic/acc_engine.sv
logic/acc_top.sv
sim/tb_clock.sv
sim/acc_tb.sv

/* Bender.yml */
package:
  name: acc_pipeline

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/acc_pkg.sv
      - logic/cmd_ingress.sv
      - logic/cmd_fifo.sv
      - logic/acc_engine.sv
      - logic/acc_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/acc_tb.sv
